/* hw/mem_pkg.sv */
package mem_pkg;

    // Data path widths
    localparam int word_width      = 32;  // Pipeline word
    localparam int half_width      = 16;  // SRAM data bus
    localparam int sram_addr_width = 18;  // SRAM halfword address

    // Start of the data region in the CPU byte address space
    localparam logic [word_width-1:0] data_base = 32'd1024;

    // Request opcode
    typedef enum logic [1:0] {
        mem_nop   = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_t;

    // SRAM access sequencer states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_high = 2'd1,  // Upper half at the even halfword
        st_low  = 2'd2,  // Lower half at the odd halfword
        st_done = 2'd3
    } sram_state_t;

endpackage

/* hw/mem_request.sv */
module mem_request (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 read_en,
    input  logic                                 write_en,
    input  logic [mem_pkg::word_width-1:0]       address,
    input  logic [mem_pkg::word_width-1:0]       write_data,
    input  logic                                 idle,
    output logic                                 start,
    output mem_pkg::mem_op_t                     op,
    output logic [mem_pkg::sram_addr_width-1:0]  half_addr,
    output logic [mem_pkg::word_width-1:0]       store_data
);
    import mem_pkg::*;

    logic [word_width-1:0]      offset;
    logic [sram_addr_width-1:0] half_addr_next;
    mem_op_t                    op_next;
    logic                       accept;

    // Byte offset into the data region
    assign offset = address - data_base;

    // Word index doubled gives the even halfword
    assign half_addr_next = {offset[sram_addr_width:2], 1'b0};

    // Read has priority when both enables are up
    always_comb begin
        if (read_en) begin
            op_next = mem_load;
        end else if (write_en) begin
            op_next = mem_store;
        end else begin
            op_next = mem_nop;
        end
    end

    // Sequencer still idle during the start cycle, so block a second accept there
    assign accept = idle && !start && (read_en || write_en);

    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
            op    <= mem_nop;
        end else begin
            start <= accept;
            if (accept) begin
                op <= op_next;
            end
        end
    end

    // Request payload, held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            half_addr  <= half_addr_next;
            store_data <= write_data;
        end
    end

endmodule

/* hw/sram_ctrl.sv */
module sram_ctrl #(
    parameter int unsigned wait_cycles = 1
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start,
    input  mem_pkg::mem_op_t                     op,
    input  logic [mem_pkg::sram_addr_width-1:0]  half_addr,
    input  logic [mem_pkg::word_width-1:0]       store_data,
    output logic                                 idle,
    output logic                                 half_valid,
    output logic                                 half_sel,
    output logic [mem_pkg::half_width-1:0]       half_data,
    output logic                                 done,
    output logic [mem_pkg::sram_addr_width-1:0]  sram_addr,
    output logic                                 ce_n,
    output logic                                 oe_n,
    output logic                                 we_n,
    output logic                                 ub_n,
    output logic                                 lb_n,
    inout  wire  [mem_pkg::half_width-1:0]       sram_dq
);
    import mem_pkg::*;

    // Wait count of the last cycle in a half
    localparam logic [2:0] last_cnt = 3'(wait_cycles);

    sram_state_t           state;
    sram_state_t           state_next;
    logic [2:0]            wait_cnt;
    logic                  active;
    logic                  last_cycle;
    logic                  is_load;
    logic                  is_store;
    logic                  we_window;
    logic [half_width-1:0] bus_data;

    assign active     = (state == st_high) || (state == st_low);
    assign last_cycle = (wait_cnt == last_cnt);
    assign is_load    = (op == mem_load);
    assign is_store   = (op == mem_store);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start && op != mem_nop) begin
                    state_next = st_high;
                end
            end
            st_high: begin
                if (last_cycle) begin
                    state_next = st_low;
                end
            end
            st_low: begin
                if (last_cycle) begin
                    state_next = st_done;
                end
            end
            st_done: state_next = st_idle;  // One cycle only
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            wait_cnt <= 3'd0;
        end else begin
            state <= state_next;
            // Per-half wait count restarts at each half
            if (active && !last_cycle) begin
                wait_cnt <= wait_cnt + 3'd1;
            end else begin
                wait_cnt <= 3'd0;
            end
        end
    end

    // Status back to the request and result sides
    assign idle = (state == st_idle);
    assign done = (state == st_done);

    // Load data is taken on the last cycle of each half
    assign half_valid = active && is_load && last_cycle;
    assign half_sel   = (state == st_high);
    assign half_data  = sram_dq;

    // Even halfword first, then the odd one
    assign sram_addr = (state == st_low) ? half_addr + 1'b1 : half_addr;

    assign ce_n = !active;
    assign ub_n = !active;
    assign lb_n = !active;
    assign oe_n = !(active && is_load);

    // Write strobe rises on the last cycle so data holds past it
    assign we_window = (wait_cycles == 0) || (wait_cnt < last_cnt);
    assign we_n      = !(active && is_store && we_window);

    assign bus_data = (state == st_high) ? store_data[word_width-1 -: half_width]
                                         : store_data[half_width-1:0];

    // Bus released unless a store is in progress
    assign sram_dq = (active && is_store) ? bus_data : {half_width{1'bz}};

endmodule

/* hw/mem_result.sv */
module mem_result (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic                            half_valid,
    input  logic                            half_sel,
    input  logic [mem_pkg::half_width-1:0]  half_data,
    input  logic                            done,
    output logic [mem_pkg::word_width-1:0]  read_data,
    output logic                            ready,
    output logic                            freeze
);
    import mem_pkg::*;

    // Assemble the loaded word one half at a time
    always_ff @(posedge clk) begin
        if (rst) begin
            read_data <= '0;
        end else if (half_valid) begin
            if (half_sel) begin
                read_data[word_width-1 -: half_width] <= half_data;  // Upper half
            end else begin
                read_data[half_width-1:0] <= half_data;
            end
        end
    end

    // Stall flag for the rest of the pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            freeze <= 1'b0;
        end else if (start) begin
            freeze <= 1'b1;
        end else if (done) begin
            freeze <= 1'b0;  // Drops after the ready cycle
        end
    end

    assign ready = done;

endmodule

/* hw/mem_stage_top.sv */
module mem_stage_top #(
    parameter int unsigned wait_cycles = 1
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 read_en,
    input  logic                                 write_en,
    input  logic [mem_pkg::word_width-1:0]       address,
    input  logic [mem_pkg::word_width-1:0]       write_data,
    output logic [mem_pkg::word_width-1:0]       read_data,
    output logic                                 ready,
    output logic                                 freeze,
    output logic [mem_pkg::sram_addr_width-1:0]  sram_addr,
    output logic                                 ce_n,
    output logic                                 oe_n,
    output logic                                 we_n,
    output logic                                 ub_n,
    output logic                                 lb_n,
    inout  wire  [mem_pkg::half_width-1:0]       sram_dq
);
    import mem_pkg::*;

    // Request to sequencer
    logic                       idle;
    logic                       start;
    mem_op_t                    op;
    logic [sram_addr_width-1:0] half_addr;
    logic [word_width-1:0]      store_data;

    // Sequencer to result
    logic                       half_valid;
    logic                       half_sel;
    logic [half_width-1:0]      half_data;
    logic                       done;

    mem_request i_request (
        .clk        (clk),
        .rst        (rst),
        .read_en    (read_en),
        .write_en   (write_en),
        .address    (address),
        .write_data (write_data),
        .idle       (idle),
        .start      (start),
        .op         (op),
        .half_addr  (half_addr),
        .store_data (store_data)
    );

    sram_ctrl #(
        .wait_cycles (wait_cycles)
    ) i_sram_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .half_addr  (half_addr),
        .store_data (store_data),
        .idle       (idle),
        .half_valid (half_valid),
        .half_sel   (half_sel),
        .half_data  (half_data),
        .done       (done),
        .sram_addr  (sram_addr),
        .ce_n       (ce_n),
        .oe_n       (oe_n),
        .we_n       (we_n),
        .ub_n       (ub_n),
        .lb_n       (lb_n),
        .sram_dq    (sram_dq)
    );

    mem_result i_result (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .half_valid (half_valid),
        .half_sel   (half_sel),
        .half_data  (half_data),
        .done       (done),
        .read_data  (read_data),
        .ready      (ready),
        .freeze     (freeze)
    );

endmodule

/* tb/sram_model.sv */
module sram_model (
    input  logic [mem_pkg::sram_addr_width-1:0]  sram_addr,
    input  logic                                 ce_n,
    input  logic                                 oe_n,
    input  logic                                 we_n,
    input  logic                                 ub_n,
    input  logic                                 lb_n,
    inout  wire  [mem_pkg::half_width-1:0]       sram_dq
);
    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    localparam int depth = 1 << sram_addr_width;

    logic [half_width-1:0] mem [0:depth-1];
    logic [half_width-1:0] read_word;

    // Fill so that every cell differs from its neighbours
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = 16'(i ^ (i >> 2));
        end
    end

    assign read_word = mem[sram_addr];

    // Output enabled read with byte lanes masked by ub_n and lb_n
    assign sram_dq = (!ce_n && !oe_n && we_n) ?
                     {ub_n ? 8'hzz : read_word[15:8], lb_n ? 8'hzz : read_word[7:0]} :
                     16'hzzzz;

    // Write follows the bus while the write strobe is low
    always @(ce_n or we_n or ub_n or lb_n or sram_addr or sram_dq) begin
        if (!ce_n && !we_n) begin
            if (!ub_n) begin
                mem[sram_addr][15:8] = sram_dq[15:8];
            end
            if (!lb_n) begin
                mem[sram_addr][7:0] = sram_dq[7:0];  // Lower byte lane
            end
        end
    end

endmodule

/* tb/mem_stage_tb.sv */
module mem_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    localparam int unsigned wait_cycles = 1;
    localparam int num_rows   = 10;
    localparam int latency    = 2 * (wait_cycles + 1) + 2;  // Sampling edge to ready
    localparam int timeout_ns = num_rows * (2 * (wait_cycles + 1) + 6) * 4 * 2;

    localparam logic [word_width-1:0] mid_addr  = data_base + 32'h0000_1230;
    localparam logic [word_width-1:0] last_addr = data_base + 32'h0007_fffc;  // Last word

    typedef enum {do_store, do_load, do_both} row_kind_t;

    logic                       clk;
    logic                       rst;
    logic                       read_en;
    logic                       write_en;
    logic [word_width-1:0]      address;
    logic [word_width-1:0]      write_data;
    logic [word_width-1:0]      read_data;
    logic                       ready;
    logic                       freeze;
    logic [sram_addr_width-1:0] sram_addr;
    logic                       ce_n;
    logic                       oe_n;
    logic                       we_n;
    logic                       ub_n;
    logic                       lb_n;
    wire  [half_width-1:0]      sram_dq;

    // Stimulus table
    string                 row_name   [num_rows];
    row_kind_t             row_kind   [num_rows];
    logic [word_width-1:0] row_addr   [num_rows];
    logic [word_width-1:0] row_data   [num_rows];
    logic [word_width-1:0] row_expect [num_rows];

    logic [word_width-1:0] shadow [logic [word_width-1:0]];  // Last word stored per address
    int n_rows;
    int errors;
    int tests_ok;
    int tests_bad;

    mem_stage_top #(
        .wait_cycles (wait_cycles)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .read_en    (read_en),
        .write_en   (write_en),
        .address    (address),
        .write_data (write_data),
        .read_data  (read_data),
        .ready      (ready),
        .freeze     (freeze),
        .sram_addr  (sram_addr),
        .ce_n       (ce_n),
        .oe_n       (oe_n),
        .we_n       (we_n),
        .ub_n       (ub_n),
        .lb_n       (lb_n),
        .sram_dq    (sram_dq)
    );

    sram_model i_sram (
        .sram_addr (sram_addr),
        .ce_n      (ce_n),
        .oe_n      (oe_n),
        .we_n      (we_n),
        .ub_n      (ub_n),
        .lb_n      (lb_n),
        .sram_dq   (sram_dq)
    );

    always #2 clk = ~clk;

    // Even halfword of a word in the data region
    function automatic logic [sram_addr_width-1:0] half_index(input logic [word_width-1:0] addr);
        logic [word_width-1:0] word_idx;
        word_idx = (addr - data_base) >> 2;
        return sram_addr_width'(word_idx * 2);
    endfunction

    task automatic add_row(input string name, input row_kind_t kind,
                           input logic [word_width-1:0] addr);
        logic [word_width-1:0] data;
        data = $urandom();
        row_name[n_rows] = name;
        row_kind[n_rows] = kind;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        if (kind == do_store) begin
            shadow[addr] = data;
            row_expect[n_rows] = data;
        end else begin
            row_expect[n_rows] = shadow[addr];  // Both enables act as a load
        end
        n_rows++;
    endtask

    task automatic check_value(input string name, input logic [word_width-1:0] expected,
                               input logic [word_width-1:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic run_row(input int r);
        int cycles;
        int errors_before;
        logic [sram_addr_width-1:0] idx;
        errors_before = errors;
        read_en    = (row_kind[r] != do_store);
        write_en   = (row_kind[r] != do_load);
        address    = row_addr[r];
        write_data = row_data[r];
        cycles     = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= 2) begin
                check_value({row_name[r], " freeze"}, 1, freeze);
            end
        end while (!ready && cycles < latency + 4);
        if (!ready) begin
            $display("test %s: ready never came after %0d cycles", row_name[r], cycles);
            errors++;
        end else begin
            check_value({row_name[r], " latency"}, latency, cycles);
            if (row_kind[r] != do_store) begin
                check_value({row_name[r], " read_data"}, row_expect[r], read_data);
            end
        end
        read_en  = 1'b0;
        write_en = 1'b0;
        @(posedge clk);
        #1;
        check_value({row_name[r], " ready pulse"}, 0, ready);
        check_value({row_name[r], " freeze end"}, 0, freeze);
        if (row_kind[r] == do_store) begin
            idx = half_index(row_addr[r]);
            check_value({row_name[r], " upper half"}, row_expect[r][31:16], i_sram.mem[idx]);
            check_value({row_name[r], " lower half"}, row_expect[r][15:0],
                        i_sram.mem[idx + 18'd1]);
        end
        if (errors == errors_before) begin
            $display("test %s ok", row_name[r]);
            tests_ok++;
        end else begin
            $display("test %s failed", row_name[r]);
            tests_bad++;
        end
    endtask

    initial begin
        void'($urandom(96605));
        clk        = 1'b0;
        rst        = 1'b1;
        read_en    = 1'b0;
        write_en   = 1'b0;
        address    = '0;
        write_data = '0;
        n_rows     = 0;
        errors     = 0;
        tests_ok   = 0;
        tests_bad  = 0;

        add_row("store_base", do_store, data_base);
        add_row("store_last", do_store, last_addr);
        add_row("store_mid", do_store, mid_addr);
        add_row("load_base", do_load, data_base);
        add_row("load_last", do_load, last_addr);
        add_row("load_mid", do_load, mid_addr);
        add_row("store_base2", do_store, data_base);
        add_row("load_base2", do_load, data_base);
        add_row("both_mid", do_both, mid_addr);   // Read wins and memory stays untouched
        add_row("load_mid2", do_load, mid_addr);

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle outputs right after reset
        check_value("reset ready", 0, ready);
        check_value("reset freeze", 0, freeze);
        check_value("reset ce_n", 1, ce_n);
        check_value("reset oe_n", 1, oe_n);
        check_value("reset we_n", 1, we_n);
        check_value("reset ub_n", 1, ub_n);
        check_value("reset lb_n", 1, lb_n);
        if (errors == 0) begin
            $display("test reset ok");
            tests_ok++;
        end else begin
            $display("test reset failed");
            tests_bad++;
        end

        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end

        $display("tests: %0d ok, %0d failed", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(timeout_ns);
        $display("run timed out after %0d ns before all tests finished", timeout_ns);
        $display("Verification failed");
        $finish;
    end

endmodule

/* all.f */
hw/mem_pkg.sv
hw/mem_request.sv
hw/sram_ctrl.sv
hw/mem_result.sv
hw/mem_stage_top.sv
tb/sram_model.sv
tb/mem_stage_tb.sv

/* Makefile */
TOP := mem_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f all.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
